/* Makefile */
VERILATOR ?= verilator
TOP       ?= tb_flash_qspi_top
FILELIST  ?= flash_qspi.f
SEED      ?= 9277
LOG       ?= sim.log
BUILD_DIR ?= obj_dir

VFLAGS ?= --timing --assert --timescale 1ns/100ps --top-module $(TOP)

SRCS := $(shell grep -v '^+' $(FILELIST))

.PHONY: all lint sim clean

all: sim

lint:
	$(VERILATOR) --lint-only $(VFLAGS) -f $(FILELIST)

$(BUILD_DIR)/V$(TOP): $(SRCS) $(FILELIST)
	$(VERILATOR) --binary $(VFLAGS) -f $(FILELIST) -Mdir $(BUILD_DIR) -o V$(TOP)

sim: $(BUILD_DIR)/V$(TOP)
	$(BUILD_DIR)/V$(TOP) +verilator+seed+$(SEED) > $(LOG) 2>&1; cat $(LOG)
	@grep -q "Everything OK" $(LOG) || (echo "Simulation failed, see $(LOG)"; exit 1)

clean:
	rm -rf $(BUILD_DIR) $(LOG)

/* flash_qspi.f */
rtl/flash_qspi_pkg.sv
rtl/qspi_regs.sv
rtl/spi_byte_shifter.sv
rtl/flash_read_ctrl.sv
rtl/flash_qspi_top.sv
verif/spi_flash_model.sv
verif/tb_flash_qspi_top.sv

/* rtl/flash_qspi_pkg.sv */
package flash_qspi_pkg;

  localparam int ADDR_W         = 32;
  localparam int DATA_W         = 32;
  localparam int FLASH_ADDR_W   = 20; // Address bits forwarded to the flash.
  localparam int SPI_ADDR_BYTES = 3;
  localparam int WORD_BYTES     = 4;
  localparam int SCKDIV_W       = 8;

  // Register offsets on the register port.
  localparam logic [7:0] REG_SCKDIV = 8'h00;
  localparam logic [7:0] REG_RDCMD  = 8'h04;
  localparam logic [7:0] REG_STATUS = 8'h08;

  localparam logic [SCKDIV_W-1:0] SCKDIV_RST = 8'd1;
  localparam logic [7:0]          RDCMD_RST  = 8'h03; // Standard read opcode.

  typedef struct packed {
    logic [ADDR_W-1:0] addr;
    logic              read;
    logic [DATA_W-1:0] wdata;
  } icb_cmd_t;

  typedef struct packed {
    logic [SCKDIV_W-1:0] sckdiv;
    logic [7:0]          rd_opcode;
  } qspi_cfg_t;

endpackage

/* rtl/flash_qspi_top.sv */
module flash_qspi_top
  import flash_qspi_pkg::*;
(
  input  logic              clk,
  input  logic              arst_n_i,

  input  logic              reg_cmd_valid_i,
  output logic              reg_cmd_ready_o,
  input  icb_cmd_t          reg_cmd_i,
  output logic              reg_rsp_valid_o,
  input  logic              reg_rsp_ready_i,
  output logic [DATA_W-1:0] reg_rsp_rdata_o,

  input  logic              flash_cmd_valid_i,
  output logic              flash_cmd_ready_o,
  input  icb_cmd_t          flash_cmd_i,
  output logic              flash_rsp_valid_o,
  input  logic              flash_rsp_ready_i,
  output logic [DATA_W-1:0] flash_rsp_rdata_o,

  output logic              sck_o,
  output logic              cs_n_o,
  output logic              mosi_o,
  input  logic              miso_i
);

  qspi_cfg_t  cfg;
  logic       busy;
  logic       byte_start;
  logic [7:0] tx_byte;
  logic       byte_done;
  logic [7:0] rx_byte;

  qspi_regs u_qspi_regs (
    .clk             (clk),
    .arst_n_i        (arst_n_i),
    .reg_cmd_valid_i (reg_cmd_valid_i),
    .reg_cmd_ready_o (reg_cmd_ready_o),
    .reg_cmd_i       (reg_cmd_i),
    .reg_rsp_valid_o (reg_rsp_valid_o),
    .reg_rsp_ready_i (reg_rsp_ready_i),
    .reg_rsp_rdata_o (reg_rsp_rdata_o),
    .busy_i          (busy),
    .cfg_o           (cfg)
  );

  flash_read_ctrl u_flash_read_ctrl (
    .clk               (clk),
    .arst_n_i          (arst_n_i),
    .flash_cmd_valid_i (flash_cmd_valid_i),
    .flash_cmd_ready_o (flash_cmd_ready_o),
    .flash_cmd_i       (flash_cmd_i),
    .flash_rsp_valid_o (flash_rsp_valid_o),
    .flash_rsp_ready_i (flash_rsp_ready_i),
    .flash_rsp_rdata_o (flash_rsp_rdata_o),
    .cfg_i             (cfg),
    .busy_o            (busy),
    .byte_start_o      (byte_start),
    .tx_byte_o         (tx_byte),
    .byte_done_i       (byte_done),
    .rx_byte_i         (rx_byte),
    .cs_n_o            (cs_n_o)
  );

  spi_byte_shifter u_spi_byte_shifter (
    .clk          (clk),
    .arst_n_i     (arst_n_i),
    .cfg_i        (cfg),
    .byte_start_i (byte_start),
    .tx_byte_i    (tx_byte),
    .byte_done_o  (byte_done),
    .rx_byte_o    (rx_byte),
    .sck_o        (sck_o),
    .miso_i       (miso_i),
    .mosi_o       (mosi_o)
  );

endmodule

/* rtl/flash_read_ctrl.sv */
module flash_read_ctrl
  import flash_qspi_pkg::*;
(
  input  logic              clk,
  input  logic              arst_n_i,
  input  logic              flash_cmd_valid_i,
  output logic              flash_cmd_ready_o,
  input  icb_cmd_t          flash_cmd_i,
  output logic              flash_rsp_valid_o,
  input  logic              flash_rsp_ready_i,
  output logic [DATA_W-1:0] flash_rsp_rdata_o,
  input  qspi_cfg_t         cfg_i,
  output logic              busy_o,
  output logic              byte_start_o,
  output logic [7:0]        tx_byte_o,
  input  logic              byte_done_i,
  input  logic [7:0]        rx_byte_i,
  output logic              cs_n_o
);

  localparam int NUM_BYTES = 1 + SPI_ADDR_BYTES + WORD_BYTES;
  localparam int SPI_AW    = 8 * SPI_ADDR_BYTES;

  typedef enum logic [1:0] {
    IDLE,
    XFER,
    RESP
  } state_e;

  state_e            state_q;
  logic [2:0]        idx_q;
  logic              start_q;
  logic              cs_n_q;
  logic [7:0]        opcode_q;
  logic [SPI_AW-1:0] addr_q;
  logic [DATA_W-1:0] rdata_q;
  logic              cmd_fire;

  assign cmd_fire = flash_cmd_valid_i && flash_cmd_ready_o;

  always_ff @(posedge clk or negedge arst_n_i) begin
    if (!arst_n_i) begin
      state_q <= IDLE;
      idx_q   <= '0;
      start_q <= 1'b0;
      cs_n_q  <= 1'b1;
    end else begin
      start_q <= 1'b0;
      case (state_q)
        IDLE: begin
          if (cmd_fire) begin
            state_q <= XFER;
            idx_q   <= '0;
            start_q <= 1'b1;
            cs_n_q  <= 1'b0;
          end
        end
        XFER: begin
          if (byte_done_i) begin
            if (idx_q == 3'(NUM_BYTES - 1)) begin
              state_q <= RESP;
              cs_n_q  <= 1'b1;
            end else begin
              idx_q   <= idx_q + 3'd1;
              start_q <= 1'b1; // Next byte straight after this one.
            end
          end
        end
        RESP: begin
          if (flash_rsp_ready_i) begin
            state_q <= IDLE;
          end
        end
        default: state_q <= IDLE;
      endcase
    end
  end

  always_ff @(posedge clk) begin
    if (cmd_fire) begin
      opcode_q <= cfg_i.rd_opcode;
      addr_q   <= {{(SPI_AW - FLASH_ADDR_W){1'b0}}, flash_cmd_i.addr[FLASH_ADDR_W-1:2], 2'b00};
    end
    if (state_q == XFER && byte_done_i && idx_q >= 3'(1 + SPI_ADDR_BYTES)) begin
      rdata_q <= {rx_byte_i, rdata_q[DATA_W-1:8]}; // First byte ends in 7:0.
    end
  end

  always_comb begin
    case (idx_q)
      3'd0:    tx_byte_o = opcode_q;
      3'd1:    tx_byte_o = addr_q[23:16];
      3'd2:    tx_byte_o = addr_q[15:8];
      3'd3:    tx_byte_o = addr_q[7:0];
      default: tx_byte_o = 8'h00; // Dummy bytes while reading.
    endcase
  end

  assign flash_cmd_ready_o = (state_q == IDLE);
  assign flash_rsp_valid_o = (state_q == RESP);
  assign flash_rsp_rdata_o = rdata_q;
  assign busy_o            = (state_q != IDLE);
  assign byte_start_o      = start_q;
  assign cs_n_o            = cs_n_q;

  // Flash writes are not supported.
  a_read_only: assert property (@(posedge clk) disable iff (!arst_n_i)
    cmd_fire |-> flash_cmd_i.read);

  a_cs_during_byte: assert property (@(posedge clk) disable iff (!arst_n_i)
    byte_start_o |-> !cs_n_o throughout byte_done_i[->1]);

endmodule

/* rtl/qspi_regs.sv */
module qspi_regs
  import flash_qspi_pkg::*;
(
  input  logic              clk,
  input  logic              arst_n_i,
  input  logic              reg_cmd_valid_i,
  output logic              reg_cmd_ready_o,
  input  icb_cmd_t          reg_cmd_i,
  output logic              reg_rsp_valid_o,
  input  logic              reg_rsp_ready_i,
  output logic [DATA_W-1:0] reg_rsp_rdata_o,
  input  logic              busy_i,
  output qspi_cfg_t         cfg_o
);

  logic              cmd_fire;
  logic [7:0]        offset;
  logic [DATA_W-1:0] rd_value;
  qspi_cfg_t         cfg_q;
  logic              rsp_valid_q;
  logic [DATA_W-1:0] rsp_rdata_q;

  assign cmd_fire = reg_cmd_valid_i && reg_cmd_ready_o;
  assign offset   = reg_cmd_i.addr[7:0];

  always_comb begin
    rd_value = '0;
    case (offset)
      REG_SCKDIV: rd_value = DATA_W'(cfg_q.sckdiv);
      REG_RDCMD:  rd_value = DATA_W'(cfg_q.rd_opcode);
      REG_STATUS: rd_value = DATA_W'(busy_i); // Bit 0 is busy.
      default:    rd_value = '0;
    endcase
  end

  always_ff @(posedge clk or negedge arst_n_i) begin
    if (!arst_n_i) begin
      cfg_q.sckdiv    <= SCKDIV_RST;
      cfg_q.rd_opcode <= RDCMD_RST;
    end else if (cmd_fire && !reg_cmd_i.read) begin
      case (offset)
        REG_SCKDIV: cfg_q.sckdiv    <= reg_cmd_i.wdata[SCKDIV_W-1:0];
        REG_RDCMD:  cfg_q.rd_opcode <= reg_cmd_i.wdata[7:0];
        default:    ; // Read only or unmapped.
      endcase
    end
  end

  always_ff @(posedge clk or negedge arst_n_i) begin
    if (!arst_n_i) begin
      rsp_valid_q <= 1'b0;
    end else if (cmd_fire) begin
      rsp_valid_q <= 1'b1;
    end else if (reg_rsp_ready_i) begin
      rsp_valid_q <= 1'b0;
    end
  end

  always_ff @(posedge clk) begin
    if (cmd_fire) begin
      rsp_rdata_q <= reg_cmd_i.read ? rd_value : '0; // Writes answer with zero.
    end
  end

  assign reg_cmd_ready_o = !rsp_valid_q;
  assign reg_rsp_valid_o = rsp_valid_q;
  assign reg_rsp_rdata_o = rsp_rdata_q;
  assign cfg_o           = cfg_q;

  // A pending response holds with its data until it is taken.
  a_rsp_hold: assert property (@(posedge clk) disable iff (!arst_n_i)
    reg_rsp_valid_o && !reg_rsp_ready_i |=> reg_rsp_valid_o && $stable(reg_rsp_rdata_o));

endmodule

/* rtl/spi_byte_shifter.sv */
module spi_byte_shifter
  import flash_qspi_pkg::*;
(
  input  logic       clk,
  input  logic       arst_n_i,
  input  qspi_cfg_t  cfg_i,
  input  logic       byte_start_i,
  input  logic [7:0] tx_byte_i,
  output logic       byte_done_o,
  output logic [7:0] rx_byte_o,
  output logic       sck_o,
  input  logic       miso_i,
  output logic       mosi_o
);

  logic                active_q;
  logic [SCKDIV_W-1:0] div_lat_q;
  logic [SCKDIV_W-1:0] div_cnt_q;
  logic [3:0]          edge_cnt_q;
  logic                sck_q;
  logic [7:0]          tx_sr_q;
  logic [7:0]          rx_sr_q;
  logic                toggle;

  assign toggle = active_q && (div_cnt_q == div_lat_q); // End of a half period.

  always_ff @(posedge clk or negedge arst_n_i) begin
    if (!arst_n_i) begin
      active_q   <= 1'b0;
      div_lat_q  <= '0;
      div_cnt_q  <= '0;
      edge_cnt_q <= '0;
      sck_q      <= 1'b0;
      tx_sr_q    <= '0;
    end else begin
      if (byte_start_i) begin
        active_q   <= 1'b1;
        div_lat_q  <= cfg_i.sckdiv;
        div_cnt_q  <= '0;
        edge_cnt_q <= '0;
        sck_q      <= 1'b0;
        tx_sr_q    <= tx_byte_i; // MSB is on mosi right away.
      end else if (toggle) begin
        div_cnt_q  <= '0;
        sck_q      <= !sck_q;
        edge_cnt_q <= edge_cnt_q + 4'd1;
        if (sck_q) begin
          tx_sr_q <= {tx_sr_q[6:0], 1'b0}; // Next bit on the falling edge.
        end
        if (edge_cnt_q == 4'd15) begin
          active_q <= 1'b0;
        end
      end else if (active_q) begin
        div_cnt_q <= div_cnt_q + 1'b1;
      end
    end
  end

  always_ff @(posedge clk) begin
    if (toggle && !sck_q) begin
      rx_sr_q <= {rx_sr_q[6:0], miso_i}; // Sample on the rising edge.
    end
  end

  assign byte_done_o = toggle && (edge_cnt_q == 4'd15); // Last falling edge ends the byte.
  assign rx_byte_o   = rx_sr_q;
  assign sck_o       = sck_q;
  assign mosi_o      = tx_sr_q[7];

  a_no_overlap: assert property (@(posedge clk) disable iff (!arst_n_i)
    byte_start_i |-> !active_q);

endmodule

/* verif/spi_flash_model.sv */
module spi_flash_model
  import flash_qspi_pkg::*;
(
  input  logic sck_i,
  input  logic cs_n_i,
  input  logic mosi_i,
  output logic miso_o
);

  timeunit 1ns;
  timeprecision 100ps;

  localparam int         CMD_BITS      = 8 + 8 * SPI_ADDR_BYTES; // Opcode and address.
  localparam logic [7:0] FLASH_PATTERN = 8'h5A;

  logic [CMD_BITS-1:0] cmd_sr   = '0;
  int                  rise_cnt = 0;
  logic                miso_q   = 1'b0;

  function automatic logic [7:0] byte_at(input logic [23:0] addr, input logic [7:0] op);
    return addr[7:0] ^ op ^ FLASH_PATTERN;
  endfunction

  // Opcode and address shift in on rising SCK.
  always @(posedge sck_i or posedge cs_n_i) begin
    if (cs_n_i) begin
      rise_cnt <= 0; // Deselect restarts the command.
    end else begin
      if (rise_cnt < CMD_BITS) begin
        cmd_sr <= {cmd_sr[CMD_BITS-2:0], mosi_i};
      end
      rise_cnt <= rise_cnt + 1;
    end
  end

  // Data bytes go out on falling SCK with the address counting up.
  always @(negedge sck_i) begin
    int         bit_idx;
    logic [7:0] data;
    if (!cs_n_i && rise_cnt >= CMD_BITS) begin
      bit_idx = rise_cnt - CMD_BITS;
      data    = byte_at(cmd_sr[23:0] + 24'(bit_idx / 8), cmd_sr[CMD_BITS-1 -: 8]);
      miso_q <= data[7 - (bit_idx % 8)]; // MSB first.
    end
  end

  assign miso_o = miso_q;

endmodule

/* verif/tb_flash_qspi_top.sv */
module tb_flash_qspi_top
  import flash_qspi_pkg::*;
();

  timeunit 1ns;
  timeprecision 100ps;

  localparam int         CLK_PERIOD     = 40;
  localparam int         DRIVE_DELAY    = 2;
  localparam int         REG_TIMEOUT    = 100;
  localparam int         FLASH_TIMEOUT  = 40000;
  localparam int         NUM_RAND_READS = 20;
  localparam logic [7:0] FLASH_PATTERN  = 8'h5A;

  logic              clk;
  logic              arst_n;
  logic              reg_cmd_valid;
  logic              reg_cmd_ready;
  icb_cmd_t          reg_cmd;
  logic              reg_rsp_valid;
  logic              reg_rsp_ready;
  logic [DATA_W-1:0] reg_rsp_rdata;
  logic              flash_cmd_valid;
  logic              flash_cmd_ready;
  icb_cmd_t          flash_cmd;
  logic              flash_rsp_valid;
  logic              flash_rsp_ready;
  logic [DATA_W-1:0] flash_rsp_rdata;
  logic              sck;
  logic              cs_n;
  logic              mosi;
  logic              miso;

  int                errors;
  int                checks;
  int                cs_cycles;
  bit                timed_out;
  string             test_name;
  logic [7:0]        cur_opcode;
  logic [DATA_W-1:0] expected_q[$];

  initial begin
    clk = 1'b0;
    forever #(CLK_PERIOD / 2) clk = !clk;
  end

  flash_qspi_top uut (
    .clk               (clk),
    .arst_n_i          (arst_n),
    .reg_cmd_valid_i   (reg_cmd_valid),
    .reg_cmd_ready_o   (reg_cmd_ready),
    .reg_cmd_i         (reg_cmd),
    .reg_rsp_valid_o   (reg_rsp_valid),
    .reg_rsp_ready_i   (reg_rsp_ready),
    .reg_rsp_rdata_o   (reg_rsp_rdata),
    .flash_cmd_valid_i (flash_cmd_valid),
    .flash_cmd_ready_o (flash_cmd_ready),
    .flash_cmd_i       (flash_cmd),
    .flash_rsp_valid_o (flash_rsp_valid),
    .flash_rsp_ready_i (flash_rsp_ready),
    .flash_rsp_rdata_o (flash_rsp_rdata),
    .sck_o             (sck),
    .cs_n_o            (cs_n),
    .mosi_o            (mosi),
    .miso_i            (miso)
  );

  spi_flash_model u_flash (
    .sck_i  (sck),
    .cs_n_i (cs_n),
    .mosi_i (mosi),
    .miso_o (miso)
  );

  // Byte i of the word sits at the aligned flash address plus i, first byte in 7:0.
  function automatic logic [DATA_W-1:0] expected_word(input logic [7:0] op,
                                                      input logic [ADDR_W-1:0] addr);
    logic [23:0]       flash_addr;
    logic [23:0]       byte_addr;
    logic [DATA_W-1:0] word;
    int                i;
    flash_addr = {4'h0, addr[FLASH_ADDR_W-1:2], 2'b00};
    for (i = 0; i < WORD_BYTES; i++) begin
      byte_addr        = flash_addr + 24'(i);
      word[8*i +: 8]   = byte_addr[7:0] ^ op ^ FLASH_PATTERN;
    end
    return word;
  endfunction

  // Sixteen SCK half periods per byte and one idle cycle after each byte done.
  function automatic int cs_low_cycles(input int sckdiv);
    return (1 + SPI_ADDR_BYTES + WORD_BYTES) * (16 * (sckdiv + 1) + 1);
  endfunction

  task automatic check_value(input string name, input logic [31:0] exp, input logic [31:0] act);
    checks++;
    if (act !== exp) begin
      errors++;
      $display("[ERROR] %s expected %h actual %h", name, exp, act);
    end
  endtask

  task automatic finish_run();
    $display("Checks: %0d, errors: %0d", checks, errors);
    if (errors == 0) begin
      $display("Everything OK");
    end else begin
      $display("Something failed");
    end
    $finish;
  endtask

  task automatic check_wait(input bit seen, input string what);
    if (!seen) begin
      errors++;
      $display("Timeout in %s while waiting for %s", test_name, what);
      timed_out = 1'b1;
    end
  endtask

  task automatic reg_access(input logic rd, input logic [7:0] off, input logic [31:0] wdata,
                            output logic [31:0] rdata);
    int n;
    bit seen;
    @(posedge clk);
    #DRIVE_DELAY;
    reg_cmd.addr  = {24'h0, off};
    reg_cmd.read  = rd;
    reg_cmd.wdata = wdata;
    reg_cmd_valid = 1'b1;
    n    = 0;
    seen = 1'b0;
    while (!seen && n < REG_TIMEOUT) begin
      @(negedge clk);
      seen = reg_cmd_ready;
      n++;
    end
    check_wait(seen, "register command ready");
    @(posedge clk);
    #DRIVE_DELAY;
    reg_cmd_valid = 1'b0;
    n    = 0;
    seen = 1'b0;
    while (!seen && n < REG_TIMEOUT) begin
      @(negedge clk);
      seen = reg_rsp_valid;
      n++;
    end
    check_wait(seen, "register response");
    check_value({test_name, " reg cmd ready"}, 32'd0, 32'(reg_cmd_ready));
    rdata = reg_rsp_rdata;
  endtask

  task automatic read_expect(input logic [7:0] off, input logic [31:0] exp);
    logic [31:0] rd;
    reg_access(1'b1, off, '0, rd);
    check_value(test_name, exp, rd);
  endtask

  task automatic write_reg(input logic [7:0] off, input logic [31:0] data);
    logic [31:0] rd;
    reg_access(1'b0, off, data, rd);
    check_value({test_name, " write rdata"}, '0, rd);
  endtask

  task automatic flash_read(input logic [ADDR_W-1:0] addr, input int stall);
    logic [DATA_W-1:0] held;
    int                n;
    int                i;
    bit                seen;
    @(posedge clk);
    #DRIVE_DELAY;
    flash_cmd.addr  = addr;
    flash_cmd.read  = 1'b1;
    flash_cmd.wdata = '0;
    flash_cmd_valid = 1'b1;
    flash_rsp_ready = (stall == 0);
    expected_q.push_back(expected_word(cur_opcode, addr));
    n    = 0;
    seen = 1'b0;
    while (!seen && n < REG_TIMEOUT) begin
      @(negedge clk);
      seen = flash_cmd_ready;
      n++;
    end
    check_wait(seen, "flash command ready");
    @(posedge clk);
    #DRIVE_DELAY;
    flash_cmd_valid = 1'b0;
    n    = 0;
    seen = 1'b0;
    while (!seen && n < FLASH_TIMEOUT) begin
      @(negedge clk);
      seen = flash_rsp_valid;
      n++;
    end
    check_wait(seen, "flash response");
    held = flash_rsp_rdata;
    for (i = 0; i < stall; i++) begin
      check_value({test_name, " held valid"}, 32'd1, 32'(flash_rsp_valid));
      check_value({test_name, " held data"}, held, flash_rsp_rdata);
      check_value({test_name, " cmd ready"}, 32'd0, 32'(flash_cmd_ready));
      @(posedge clk);
      #DRIVE_DELAY;
      if (i == stall - 1) begin
        flash_rsp_ready = 1'b1;
      end
      @(negedge clk);
    end
  endtask

  task automatic measure_cs_low(output int cycles);
    int n;
    bit seen;
    n    = 0;
    seen = 1'b0;
    while (!seen && n < REG_TIMEOUT) begin
      @(negedge clk);
      seen = !cs_n;
      n++;
    end
    check_wait(seen, "cs_n falling");
    cycles = 1;
    seen   = 1'b0;
    while (!seen && cycles < FLASH_TIMEOUT) begin
      @(negedge clk);
      if (cs_n) begin
        seen = 1'b1;
      end else begin
        cycles++;
      end
    end
    check_wait(seen, "cs_n rising");
  endtask

  // Response transfers on the next rising edge.
  always @(negedge clk) begin
    if (flash_rsp_valid && flash_rsp_ready) begin
      if (expected_q.size() == 0) begin
        errors++;
        $display("Flash response in %s with no read outstanding", test_name);
      end else begin
        check_value(test_name, expected_q.pop_front(), flash_rsp_rdata);
      end
    end
  end

  // A timed out wait ends the run.
  initial begin
    wait (timed_out);
    finish_run();
  end

  initial begin
    void'($urandom(9277));
    arst_n          = 1'b0;
    reg_cmd_valid   = 1'b0;
    reg_cmd         = '0;
    reg_rsp_ready   = 1'b1;
    flash_cmd_valid = 1'b0;
    flash_cmd       = '0;
    flash_rsp_ready = 1'b0;
    errors          = 0;
    checks          = 0;
    cur_opcode      = RDCMD_RST;
    test_name       = "reset";
    repeat (2) @(posedge clk);
    #DRIVE_DELAY;
    arst_n = 1'b1;

    test_name = "reset_values";
    read_expect(REG_SCKDIV, 32'(SCKDIV_RST));
    read_expect(REG_RDCMD, 32'(RDCMD_RST));
    read_expect(REG_STATUS, 32'd0);
    read_expect(8'h0C, 32'd0);

    test_name = "reg_write_read";
    write_reg(REG_SCKDIV, 32'd5);
    write_reg(REG_RDCMD, 32'h3B);
    read_expect(REG_SCKDIV, 32'd5);
    read_expect(REG_RDCMD, 32'h3B);
    write_reg(8'h0C, 32'hFFFF_FFFF);
    read_expect(8'h0C, 32'd0);
    write_reg(REG_SCKDIV, 32'(SCKDIV_RST));
    write_reg(REG_RDCMD, 32'(RDCMD_RST));

    test_name = "random_reads";
    repeat (NUM_RAND_READS) flash_read($urandom(), 0);

    test_name = "fast_read_opcode";
    write_reg(REG_SCKDIV, 32'd3);
    write_reg(REG_RDCMD, 32'h0B);
    cur_opcode = 8'h0B;
    fork
      flash_read($urandom(), 0);
      measure_cs_low(cs_cycles);
    join
    check_value("fast_read_opcode cs low cycles", cs_low_cycles(3), cs_cycles);
    repeat (3) flash_read($urandom(), 0);

    test_name = "back_pressure";
    repeat (5) begin
      fork
        flash_read($urandom(), int'($urandom_range(6, 1)));
        begin
          repeat (20) @(posedge clk);
          read_expect(REG_STATUS, 32'd1); // Busy mid transaction.
        end
      join
    end

    @(posedge clk);
    check_value("outstanding reads", 32'd0, 32'(expected_q.size()));
    finish_run();
  end

endmodule
